/* filter_cond_defines.svh */
// Width, depth and threshold definitions shared by the filter-condition lane
`ifndef FILTER_COND_DEFINES_SVH
`define FILTER_COND_DEFINES_SVH

// Packet data word
`define FIELD_W     16
`define NUM_FIELDS  4

// Route id carried in the packet metadata
`define ROUTE_W     8

// Per-sequence pass counter
`define COUNT_W     16

// FIFO sizing
`define FIFO_DEPTH  16
// Leaves headroom for the two packets that may still be in flight
`define PROG_THRESH 8

`endif

/* filter_packet_pkg.sv */
// Packet types for the filter-condition lane: metadata, data word views and enums
`include "filter_cond_defines.svh"

package filter_packet_pkg;

    localparam int DATA_W = `NUM_FIELDS * `FIELD_W;

    typedef enum logic {
        SEQ_RUNNING = 1'b0,
        SEQ_DONE    = 1'b1
    } seq_state_t;

    typedef enum logic {
        CMD_DATA    = 1'b0,
        CMD_CONTROL = 1'b1
    } cmd_t;

    typedef struct packed {
        logic [`ROUTE_W-1:0] route_to;
        logic [`ROUTE_W-1:0] route_from;
        logic [`ROUTE_W-1:0] seq_src;
        seq_state_t          seq_state;
        cmd_t                cmd;
    } packet_meta_t;

    // Control view, pass count in the upper bits
    typedef struct packed {
        logic [`COUNT_W-1:0]        count;
        logic [DATA_W-`COUNT_W-1:0] pad;
    } packet_count_t;

    typedef union packed {
        logic [`NUM_FIELDS-1:0][`FIELD_W-1:0] fields;
        packet_count_t                        count_view;
    } packet_data_t;

    typedef struct packed {
        packet_meta_t meta;
        packet_data_t data;
    } packet_t;

endpackage

/* filter_config_pkg.sv */
// Configuration word of the filter-condition lane and its compare operations
`include "filter_cond_defines.svh"

package filter_config_pkg;

    typedef enum logic [1:0] {
        OP_EQ = 2'd0,
        OP_NE = 2'd1,
        OP_LT = 2'd2,
        OP_GT = 2'd3
    } filter_op_t;

    // 38 bits, field_sel first
    typedef struct packed {
        logic [$clog2(`NUM_FIELDS)-1:0] field_sel;
        filter_op_t                     op;
        logic [`FIELD_W-1:0]            threshold;
        // Inverts the compare result
        logic                           filter_pass;
        // Forward every packet, steered by the result
        logic                           conditional_flag;
        logic [`ROUTE_W-1:0]            route_if;
        logic [`ROUTE_W-1:0]            route_else;
    } filter_config_t;

endpackage

/* packet_fifo.sv */
// Synchronous first-word-fall-through packet FIFO with a programmable-full flag
`include "filter_cond_defines.svh"

module packet_fifo #(
    parameter int DEPTH  = `FIFO_DEPTH,
    parameter int THRESH = `PROG_THRESH
) (
    input  logic                       ap_clk,
    input  logic                       areset_generator,
    input  logic                       wr_en,
    input  filter_packet_pkg::packet_t din,
    input  logic                       rd_en,
    output logic                       valid,
    output filter_packet_pkg::packet_t dout,
    output logic                       prog_full,
    output logic                       empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    filter_packet_pkg::packet_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(DEPTH));
    assign empty     = (count == '0);
    assign prog_full = (count >= CNT_W'(THRESH));

    // Head falls through, no read latency
    assign valid = ~empty;
    assign dout  = mem[rd_ptr];

    assign pop  = rd_en & ~empty;
    assign push = wr_en & (~full | pop);

    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Neighbours must respect the fill level
    a_no_overflow: assert property (@(posedge ap_clk) disable iff (areset_generator)
        !(wr_en && full && !rd_en))
        else $error("packet_fifo write while full");

    a_no_underflow: assert property (@(posedge ap_clk) disable iff (areset_generator)
        !(rd_en && empty))
        else $error("packet_fifo read while empty");

endmodule

/* filter_cond_kernel.sv */
// Compare kernel: selects one data field, tests it against the threshold, registers the flag
`include "filter_cond_defines.svh"

module filter_cond_kernel (
    input  logic                              ap_clk,
    input  logic                              areset_generator,
    input  logic                              in_valid,
    input  filter_config_pkg::filter_config_t cfg,
    input  filter_packet_pkg::packet_data_t   data,
    output logic                              result_flag
);

    logic [`FIELD_W-1:0] field;
    logic                cmp;

    assign field = data.fields[cfg.field_sel];

    always_comb begin
        case (cfg.op)
            filter_config_pkg::OP_EQ: cmp = (field == cfg.threshold);
            filter_config_pkg::OP_NE: cmp = (field != cfg.threshold);
            filter_config_pkg::OP_LT: cmp = (field < cfg.threshold);
            filter_config_pkg::OP_GT: cmp = (field > cfg.threshold);
            default:                  cmp = 1'b0;
        endcase
    end

    // Flag lines up with the stage 1 packet register in the route stage
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            result_flag <= 1'b0;
        end else if (in_valid) begin
            result_flag <= cmp ^ cfg.filter_pass;
        end
    end

endmodule

/* filter_cond_route.sv */
// Route stage: pops the input FIFO, applies pass and route rules, splits data and control
`include "filter_cond_defines.svh"

module filter_cond_route (
    input  logic                              ap_clk,
    input  logic                              areset_generator,
    input  logic                              configured,
    input  filter_config_pkg::filter_config_t cfg,
    input  logic                              in_valid,
    input  filter_packet_pkg::packet_t        in_packet,
    input  logic                              engine_full,
    input  logic                              control_full,
    output logic                              in_pop,
    output logic                              engine_wr,
    output filter_packet_pkg::packet_t        engine_pkt,
    output logic                              control_wr,
    output filter_packet_pkg::packet_t        control_pkt,
    output logic                              seq_done_emit,
    output logic                              busy_pipe
);

    logic                       s1_valid;
    filter_packet_pkg::packet_t s1_pkt;
    logic                       s1_done;
    logic                       pass;
    logic [`COUNT_W-1:0]        pass_count;
    filter_packet_pkg::packet_t data_pkt;
    filter_packet_pkg::packet_t ctrl_pkt;

    assign s1_done = s1_valid & (s1_pkt.meta.seq_state == filter_packet_pkg::SEQ_DONE);

    // Reads stop behind a sequence-done packet until the lane is set up again
    assign in_pop = configured & in_valid & ~engine_full & ~control_full
                  & ~s1_done & ~control_wr;

    filter_cond_kernel filter_cond_kernel_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .in_valid         (in_pop),
        .cfg              (cfg),
        .data             (in_packet.data),
        .result_flag      (pass)
    );

    // ----------------------------------------------------------
    // Stage 1, packet beside the kernel register
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_pop;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (in_pop) begin
            s1_pkt <= in_packet;
        end
    end

    // ----------------------------------------------------------
    // Stage 2, decision register
    // ----------------------------------------------------------
    always_comb begin
        data_pkt = s1_pkt;
        if (cfg.conditional_flag) begin
            data_pkt.meta.route_to = pass ? cfg.route_if : cfg.route_else;
        end

        // Reply goes back to whoever opened the sequence
        ctrl_pkt                       = s1_pkt;
        ctrl_pkt.meta.route_to         = s1_pkt.meta.seq_src;
        ctrl_pkt.meta.route_from       = s1_pkt.meta.seq_src;
        ctrl_pkt.meta.cmd              = filter_packet_pkg::CMD_CONTROL;
        ctrl_pkt.data.count_view.count = pass_count;
        ctrl_pkt.data.count_view.pad   = '0;
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            engine_wr  <= 1'b0;
            control_wr <= 1'b0;
            pass_count <= '0;
        end else begin
            engine_wr  <= s1_valid & ~s1_done & (pass | cfg.conditional_flag);
            control_wr <= s1_done;
            if (s1_done) begin
                pass_count <= '0;
            end else if (s1_valid & pass) begin
                pass_count <= pass_count + 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (s1_valid) begin
            engine_pkt  <= data_pkt;
            control_pkt <= ctrl_pkt;
        end
    end

    assign seq_done_emit = control_wr;
    assign busy_pipe     = s1_valid | engine_wr | control_wr;

endmodule

/* filter_cond_control.sv */
// Lane FSM: start, configuration fetch, busy until sequence done, drained done level
module filter_cond_control (
    input  logic                              ap_clk,
    input  logic                              areset_generator,
    input  logic                              start,
    input  logic                              cfg_valid,
    input  filter_config_pkg::filter_config_t cfg_word,
    input  logic                              seq_done_emit,
    input  logic                              busy_pipe,
    input  logic                              fifos_empty,
    output logic                              cfg_request,
    output logic                              configured,
    output filter_config_pkg::filter_config_t cfg,
    output logic                              done
);

    localparam logic [1:0] IDLE       = 2'd0;
    localparam logic [1:0] SETUP_REQ  = 2'd1;
    localparam logic [1:0] SETUP_WAIT = 2'd2;
    localparam logic [1:0] BUSY       = 2'd3;

    logic [1:0] state;
    logic [1:0] next_state;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start) begin
                    next_state = SETUP_REQ;
                end
            end
            SETUP_REQ: begin
                next_state = SETUP_WAIT;
            end
            SETUP_WAIT: begin
                if (cfg_valid) begin
                    next_state = BUSY;
                end
            end
            BUSY: begin
                // Config stays live until the control packet is out
                if (seq_done_emit) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (state == SETUP_WAIT && cfg_valid) begin
            cfg <= cfg_word;
        end
    end

    assign cfg_request = (state == SETUP_REQ);
    assign configured  = (state == BUSY);

    // Idle with nothing in the pipe or the FIFOs
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            done <= 1'b0;
        end else begin
            done <= (state == IDLE) & ~busy_pipe & fifos_empty;
        end
    end

    a_cfg_only_when_waiting: assert property (@(posedge ap_clk) disable iff (areset_generator)
        cfg_valid |-> state == SETUP_WAIT)
        else $error("cfg_valid outside the configuration wait");

endmodule

/* filter_cond_top.sv */
// Filter-condition lane top: input FIFO, control FSM, route stage and two output FIFOs
`include "filter_cond_defines.svh"

module filter_cond_top (
    input  logic                              ap_clk,
    input  logic                              areset_generator,
    input  logic                              start,
    input  logic                              cfg_valid,
    input  filter_config_pkg::filter_config_t cfg_word,
    input  logic                              response_valid,
    input  filter_packet_pkg::packet_t        response_packet,
    input  logic                              engine_rd_en,
    input  logic                              control_rd_en,
    output logic                              cfg_request,
    output logic                              engine_valid,
    output filter_packet_pkg::packet_t        engine_packet,
    output logic                              control_valid,
    output filter_packet_pkg::packet_t        control_packet,
    output logic                              done
);

    logic                              in_valid;
    filter_packet_pkg::packet_t        in_head;
    logic                              in_empty;
    logic                              in_pop;
    logic                              engine_wr;
    filter_packet_pkg::packet_t        engine_pkt;
    logic                              engine_full;
    logic                              engine_empty;
    logic                              control_wr;
    filter_packet_pkg::packet_t        control_pkt;
    logic                              control_full;
    logic                              control_empty;
    logic                              configured;
    filter_config_pkg::filter_config_t cfg;
    logic                              seq_done_emit;
    logic                              busy_pipe;
    logic                              fifos_empty;

    assign fifos_empty = in_empty & engine_empty & control_empty;

    // ----------------------------------------------------------
    // Input side
    // ----------------------------------------------------------
    packet_fifo #(.DEPTH(`FIFO_DEPTH), .THRESH(`PROG_THRESH)) in_fifo (
        .ap_clk (ap_clk), .areset_generator (areset_generator),
        .wr_en (response_valid), .din (response_packet), .rd_en (in_pop),
        .valid (in_valid), .dout (in_head), .prog_full (), .empty (in_empty)
    );

    filter_cond_control filter_cond_control_i (
        .ap_clk (ap_clk), .areset_generator (areset_generator),
        .start (start), .cfg_valid (cfg_valid), .cfg_word (cfg_word),
        .seq_done_emit (seq_done_emit), .busy_pipe (busy_pipe),
        .fifos_empty (fifos_empty), .cfg_request (cfg_request),
        .configured (configured), .cfg (cfg), .done (done)
    );

    filter_cond_route filter_cond_route_i (
        .ap_clk (ap_clk), .areset_generator (areset_generator),
        .configured (configured), .cfg (cfg),
        .in_valid (in_valid), .in_packet (in_head),
        .engine_full (engine_full), .control_full (control_full),
        .in_pop (in_pop), .engine_wr (engine_wr), .engine_pkt (engine_pkt),
        .control_wr (control_wr), .control_pkt (control_pkt),
        .seq_done_emit (seq_done_emit), .busy_pipe (busy_pipe)
    );

    // ----------------------------------------------------------
    // Output side, pops only while the head is valid
    // ----------------------------------------------------------
    packet_fifo #(.DEPTH(`FIFO_DEPTH), .THRESH(`PROG_THRESH)) engine_fifo (
        .ap_clk (ap_clk), .areset_generator (areset_generator),
        .wr_en (engine_wr), .din (engine_pkt), .rd_en (engine_rd_en & engine_valid),
        .valid (engine_valid), .dout (engine_packet),
        .prog_full (engine_full), .empty (engine_empty)
    );

    packet_fifo #(.DEPTH(`FIFO_DEPTH), .THRESH(`PROG_THRESH)) control_fifo (
        .ap_clk (ap_clk), .areset_generator (areset_generator),
        .wr_en (control_wr), .din (control_pkt), .rd_en (control_rd_en & control_valid),
        .valid (control_valid), .dout (control_packet),
        .prog_full (control_full), .empty (control_empty)
    );

endmodule

/* filter_cond_top_tb.sv */
// Self-checking testbench for the filter-condition lane, stimulus and expected packets from vectors
`include "filter_cond_defines.svh"

module filter_cond_top_tb;

    logic                              ap_clk;
    logic                              areset_generator;
    logic                              start;
    logic                              cfg_valid;
    filter_config_pkg::filter_config_t cfg_word;
    logic                              response_valid;
    filter_packet_pkg::packet_t        response_packet;
    logic                              engine_rd_en;
    logic                              control_rd_en;
    logic                              cfg_request;
    logic                              engine_valid;
    filter_packet_pkg::packet_t        engine_packet;
    logic                              control_valid;
    filter_packet_pkg::packet_t        control_packet;
    logic                              done;

    int value_errors;
    int other_errors;
    bit aborted;

    // Per kind of line one queue, plus per test the number of entries
    filter_config_pkg::filter_config_t cfg_q [$];
    filter_packet_pkg::packet_t        in_q [$];
    filter_packet_pkg::packet_t        eng_q [$];
    filter_packet_pkg::packet_t        ctl_q [$];
    int hold_q [$];
    int in_n [$];
    int eng_n [$];
    int ctl_n [$];

    filter_cond_top filter_cond_top_i (.*);

    initial begin
        ap_clk = 1'b0;
        forever #4 ap_clk = ~ap_clk;
    end

    task automatic check_packet(input string name, input filter_packet_pkg::packet_t got,
                                input filter_packet_pkg::packet_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic load_vectors();
        int                                fd;
        byte                               tag;
        logic [63:0]                       col [8];
        logic [1023:0]                     rest;
        filter_config_pkg::filter_config_t c;
        filter_packet_pkg::packet_t        p;
        fd = $fopen("filter_cond_vectors.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the vectors file");
            return;
        end
        while ($fscanf(fd, " %c", tag) == 1) begin
            if (tag == "#") begin
                void'($fgets(rest, fd));
            end else if (tag == "C") begin
                void'($fscanf(fd, "%h %h %h %h %h %h %h %h", col[0], col[1], col[2], col[3],
                              col[4], col[5], col[6], col[7]));
                c.field_sel        = col[0][1:0];
                c.op               = filter_config_pkg::filter_op_t'(col[1][1:0]);
                c.threshold        = col[2][`FIELD_W-1:0];
                c.filter_pass      = col[3][0];
                c.conditional_flag = col[4][0];
                c.route_if         = col[5][`ROUTE_W-1:0];
                c.route_else       = col[6][`ROUTE_W-1:0];
                cfg_q.push_back(c);
                hold_q.push_back(int'(col[7]));
                in_n.push_back(0);
                eng_n.push_back(0);
                ctl_n.push_back(0);
            end else begin
                void'($fscanf(fd, "%h %h %h %h %h %h", col[0], col[1], col[2], col[3],
                              col[4], col[5]));
                p.meta.route_to   = col[0][`ROUTE_W-1:0];
                p.meta.route_from = col[1][`ROUTE_W-1:0];
                p.meta.seq_src    = col[2][`ROUTE_W-1:0];
                p.meta.seq_state  = filter_packet_pkg::seq_state_t'(col[3][0]);
                p.meta.cmd        = filter_packet_pkg::cmd_t'(col[4][0]);
                p.data            = col[5];
                if (tag == "I") begin
                    in_q.push_back(p);
                    in_n[in_n.size()-1]++;
                end else if (tag == "E") begin
                    eng_q.push_back(p);
                    eng_n[eng_n.size()-1]++;
                end else begin
                    ctl_q.push_back(p);
                    ctl_n[ctl_n.size()-1]++;
                end
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------------------------------------
    // One test: start, configuration, packets in, outputs checked
    // ------------------------------------------------------------
    task automatic run_test(input int tid);
        int n_in;
        int n_eng;
        int n_ctl;
        int hold;
        int cycles;
        bit saw_full;
        n_in     = in_n[tid];
        n_eng    = eng_n[tid];
        n_ctl    = ctl_n[tid];
        hold     = hold_q[tid];
        saw_full = 1'b0;
        start    = 1'b1;
        @(posedge ap_clk);
        check_bit("cfg_request", cfg_request, 1'b0);
        #1 start = 1'b0;
        // Single request pulse, one cycle after start
        for (int i = 0; i < 5; i++) begin
            @(posedge ap_clk);
            check_bit("cfg_request", cfg_request, i == 0);
        end
        #1;
        cfg_valid = 1'b1;
        cfg_word  = cfg_q[tid];
        @(posedge ap_clk);
        #1 cfg_valid = 1'b0;

        cycles = 0;
        while ((n_eng > 0 || n_ctl > 0) && cycles < 400) begin
            response_valid = (n_in > 0);
            if (n_in > 0) begin
                response_packet = in_q.pop_front();
                n_in--;
            end
            engine_rd_en  = (cycles >= hold) && (hold == 0 || ($urandom % 3) != 0);
            control_rd_en = ($urandom % 2) == 1;
            @(posedge ap_clk);
            check_bit("done", done, 1'b0);
            saw_full |= filter_cond_top_i.engine_full;
            if (engine_valid && engine_rd_en) begin
                if (n_eng == 0) begin
                    other_errors++;
                    $display("Engine output appeared when no packet was expected");
                end else begin
                    check_packet("engine_packet", engine_packet, eng_q.pop_front());
                    n_eng--;
                end
            end
            if (control_valid && control_rd_en) begin
                if (n_ctl == 0) begin
                    other_errors++;
                    $display("Control output appeared when no packet was expected");
                end else begin
                    check_packet("control_packet", control_packet, ctl_q.pop_front());
                    n_ctl--;
                end
            end
            cycles++;
            #1;
        end
        response_valid = 1'b0;
        engine_rd_en   = 1'b0;
        control_rd_en  = 1'b0;
        if (n_eng > 0 || n_ctl > 0) begin
            other_errors++;
            aborted = 1'b1;
            $display("Timeout in test %0d: not all expected outputs arrived", tid);
            return;
        end
        if (hold > 0 && !saw_full) begin
            other_errors++;
            $display("Test %0d: engine FIFO never reached prog_full while held", tid);
        end

        // Lane must go idle and drained
        cycles = 0;
        do begin
            @(posedge ap_clk);
            cycles++;
        end while (done !== 1'b1 && cycles < 20);
        #1;
        if (done !== 1'b1) begin
            other_errors++;
            aborted = 1'b1;
            $display("Timeout in test %0d: done did not rise after draining", tid);
        end
        check_bit("engine_valid", engine_valid, 1'b0);
        check_bit("control_valid", control_valid, 1'b0);
    endtask

    initial begin
        areset_generator = 1'b1;
        start            = 1'b0;
        cfg_valid        = 1'b0;
        cfg_word         = '0;
        response_valid   = 1'b0;
        response_packet  = '0;
        engine_rd_en     = 1'b0;
        control_rd_en    = 1'b0;
        value_errors     = 0;
        other_errors     = 0;
        aborted          = 1'b0;
        void'($urandom(36));
        load_vectors();
        repeat (2) @(posedge ap_clk);
        #1 areset_generator = 1'b0;
        @(posedge ap_clk);
        check_bit("cfg_request", cfg_request, 1'b0);
        check_bit("engine_valid", engine_valid, 1'b0);
        check_bit("control_valid", control_valid, 1'b0);
        check_bit("done", done, 1'b0);
        @(posedge ap_clk);
        check_bit("done", done, 1'b1);
        #1;
        for (int t = 0; t < cfg_q.size() && !aborted; t++) begin
            run_test(t);
        end
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* filter_cond_vectors.txt */
# All columns hex. C: field_sel op threshold filter_pass conditional route_if route_else hold
# I, E, K: route_to route_from seq_src seq_state cmd data
C 0 0 0005 0 0 00 00 0
I 10 20 30 0 0 0000000000000005
I 11 20 30 0 0 0000000000000007
I 00 20 30 1 0 0000000000000000
E 10 20 30 0 0 0000000000000005
K 30 30 30 1 1 0001000000000000
C 1 1 0010 1 0 00 00 0
I 21 40 41 0 0 0000000000100000
I 22 40 41 0 0 0000000000110010
I 00 40 41 1 0 0000000000000000
E 21 40 41 0 0 0000000000100000
K 41 41 41 1 1 0001000000000000
C 2 2 0100 0 0 00 00 0
I 31 50 51 0 0 000000ff00000000
I 32 50 51 0 0 0000010000000000
I 00 50 51 1 0 0000000000000000
E 31 50 51 0 0 000000ff00000000
K 51 51 51 1 1 0001000000000000
C 0 3 0040 1 0 00 00 0
I 71 70 72 0 0 0000000000000040
I 73 70 72 0 0 0000000000000041
I 00 70 72 1 0 0000000000000000
E 71 70 72 0 0 0000000000000040
K 72 72 72 1 1 0001000000000000
C 3 3 8000 0 1 a1 b2 20
I 40 60 61 0 0 8001000000000000
I 41 60 61 0 0 8000000000000001
I 42 60 61 0 0 ffff000000000002
I 43 60 61 0 0 0001000000000003
I 44 60 61 0 0 9000000000000004
I 45 60 61 0 0 7fff000000000005
I 46 60 61 0 0 8000000000000006
I 47 60 61 0 0 a5a5000000000007
I 00 60 61 1 0 0000000000000000
E a1 60 61 0 0 8001000000000000
E b2 60 61 0 0 8000000000000001
E a1 60 61 0 0 ffff000000000002
E b2 60 61 0 0 0001000000000003
E a1 60 61 0 0 9000000000000004
E b2 60 61 0 0 7fff000000000005
E b2 60 61 0 0 8000000000000006
E a1 60 61 0 0 a5a5000000000007
K 61 61 61 1 1 0004000000000000

/* filter_cond_top.f */
+incdir+.
filter_packet_pkg.sv
filter_config_pkg.sv
packet_fifo.sv
filter_cond_kernel.sv
filter_cond_route.sv
filter_cond_control.sv
filter_cond_top.sv
filter_cond_top_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= filter_cond_top_tb
FILELIST  ?= filter_cond_top.f
LOG       ?= sim.log
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
